// ==== verification/dma_patterns.txt ====
# op f0 f1 f2 f3 in hex: W io_addr data, R io_addr expected, M addr count first,
# G chan first_byte jitter, E chan addr count first, I irq, A x8_base f8_base count
W 00 12345678 0 0
W 09 0000abcd 0 0
W 0a 00000002 0 0
W 0c 0000ffff 0 0
R 00 12345678 0 0
R 09 0000abcd 0 0
R 0a 00000002 0 0
R 08 00000000 0 0
W 00 00000020 0 0
W 01 00000006 0 0
W 02 00000003 0 0
G 0 40 1 0
E 0 20 6 40
R 01 00000000 0 0
R 04 00000001 0 0
I 0 0 0 0
W 04 00000001 0 0
M 60 4 a0 0
W 08 00000060 0 0
W 09 00000004 0 0
W 0a 00000005 0 0
G 1 0 0 0
E 1 60 4 a0
I 1 0 0 0
R 04 0000000a 0 0
W 04 00000002 0 0
I 0 0 0 0
W 00 00000080 0 0
W 01 00000004 0 0
W 02 00000003 0 0
W 08 00000090 0 0
W 09 00000004 0 0
W 0a 00000003 0 0
G 0 10 0 0
G 1 c0 0 0
E 0 80 4 10
E 1 90 4 c0
A 80 90 4 0

// ==== tb.f ====
verilog/dma_pkg.sv
verilog/dma_reg_decode.sv
verilog/dma8.sv
verilog/dma_mem_arb.sv
verilog/dma_status.sv
verilog/dma.sv
verification/dma_tb.sv

// ==== Bender.yml ====
package:
  name: dma

sources:
  - verilog/dma_pkg.sv
  - verilog/dma_reg_decode.sv
  - verilog/dma8.sv
  - verilog/dma_mem_arb.sv
  - verilog/dma_status.sv
  - verilog/dma.sv
  - target: test
    files:
      - verification/dma_tb.sv

// ==== verification/dma_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_tb import dma_pkg::*; ();

	logic        sys_clk = 1'b0;
	logic        rst;
	logic [31:0] in_dat;
	logic [6:0]  io_addr;
	logic        regs_wr;
	logic        regs_rd;
	logic [31:0] rd_dat;
	logic        cpu_irq;
	logic        mem_req;
	logic        mem_rw;
	logic [31:0] mem_addr;
	logic [7:0]  mem_wdat;
	logic        mem_ack;
	logic [7:0]  mem_rdat;
	logic [1:0]  dreq;
	logic [1:0]  dack;
	logic [7:0]  x8ad_in;
	logic [7:0]  f8ad_in;
	logic [7:0]  x8_out;
	logic [7:0]  f8_out;

	logic [7:0]  mem [256];
	mem_req_t    obs [$];
	logic [7:0]  x8_seen [$];
	logic [7:0]  f8_seen [$];
	int          dack_cnt [2];
	int          pause [2];
	logic [7:0]  pbyte [2];
	logic [7:0]  out_hold [2];
	logic [1:0]  want;
	logic [1:0]  jitter;
	logic [1:0]  dir_of;
	int          ack_wait;
	int          cycles = 0;
	int          limit = 200;
	int          bytes_total = 0;

	dma i_dut (.*);

	always #2 sys_clk = ~sys_clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles > limit)
			stop_run($sformatf("Run did not finish within its limit of %0d cycles", limit));
	end

	// ========================================================================
	// Memory and peripheral models
	// ========================================================================

	// A beat is recorded when its acknowledge goes out.
	always @(negedge sys_clk) begin
		if (rst) begin
			mem_ack <= 1'b0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
		end else if (mem_req && ack_wait != 0) begin
			ack_wait <= ack_wait - 1;
		end else if (mem_req) begin
			mem_ack  <= 1'b1;
			mem_rdat <= mem[mem_addr[7:0]];
			if (mem_rw)
				mem[mem_addr[7:0]] <= mem_wdat;
			obs.push_back({1'b1, mem_rw, mem_addr, mem_rw ? mem_wdat : mem[mem_addr[7:0]]});
			ack_wait <= $urandom_range(3, 0);
		end
	end

	always @(negedge sys_clk) begin
		for (int c = 0; c < 2; c++) begin
			if (dack[c]) begin
				pbyte[c] = pbyte[c] + 8'd1;
				dack_cnt[c] = dack_cnt[c] + 1;
			end
			if (!want[c]) begin
				dreq[c] <= 1'b0;
			end else if (pause[c] != 0) begin
				pause[c] = pause[c] - 1;
				dreq[c] <= 1'b0;
			end else begin
				dreq[c] <= 1'b1;
				if (jitter[c] && $urandom_range(7, 0) == 0)
					pause[c] = $urandom_range(6, 2);
			end
		end
		if (dack[0])
			x8_seen.push_back(x8_out);
		if (dack[1])
			f8_seen.push_back(f8_out);
		x8ad_in <= pbyte[0];
		f8ad_in <= pbyte[1];
	end

	// ========================================================================
	// Host tasks
	// ========================================================================

	task automatic reg_write(input logic [6:0] a, input logic [31:0] d);
		@(negedge sys_clk);
		io_addr = a;
		in_dat = d;
		regs_wr = 1'b1;
		@(negedge sys_clk);
		regs_wr = 1'b0;
	endtask

	task automatic reg_read(input logic [6:0] a, output logic [31:0] d);
		@(negedge sys_clk);
		io_addr = a;
		regs_rd = 1'b1;
		@(negedge sys_clk);
		regs_rd = 1'b0;
		d = rd_dat;
	endtask

	task automatic transfer_end(input int c, input logic [31:0] a, input int n,
			input logic [7:0] first);
		logic [31:0] st;
		logic [7:0]  seen;
		bytes_total += n;
		limit = 200 + 40 * bytes_total;
		do
			reg_read(ADDR_STATUS, st);
		while (!st[c]);
		want[c] = 1'b0;
		check_eq(dack_cnt[c], n, "dack pulse count");
		for (int i = 0; i < n; i++) begin
			seen = c ? f8_seen[i] : x8_seen[i];
			check_eq(mem[8'(a + i)], 8'(first + i), $sformatf("memory byte at %h", a + i));
			// Only a memory read latches a new byte onto the out port.
			if (!dir_of[c])
				check_eq(seen, 8'(first + i), "peripheral out byte");
			else
				check_eq(seen, out_hold[c], "held peripheral out byte");
		end
		if (!dir_of[c])
			out_hold[c] = 8'(first + n - 1);
	endtask

	task automatic beat_order(input logic [31:0] x_base, input logic [31:0] f_base, input int n);
		check_eq(obs.size(), 2 * n, "memory beat count");
		for (int k = 0; k < n; k++) begin
			check_eq(obs[2 * k].addr, x_base + k, "x8 beat address");
			check_eq(obs[2 * k + 1].addr, f_base + k, "f8 beat address");
		end
	endtask

	initial begin
		int          fd;
		int          n_read;
		int          ch;
		logic [63:0] op;
		logic [799:0] skip;
		logic [31:0] p0, p1, p2, p3;
		logic [31:0] got;
		n_read = $urandom(32'h331a);
		ack_wait = $urandom_range(3, 0);
		rst = 1'b1;
		in_dat = '0;
		io_addr = '0;
		regs_wr = 1'b0;
		regs_rd = 1'b0;
		mem_ack = 1'b0;
		mem_rdat = '0;
		dreq = '0;
		x8ad_in = '0;
		f8ad_in = '0;
		pbyte = '{8'd0, 8'd0};
		out_hold = '{8'd0, 8'd0};
		want = '0;
		jitter = '0;
		dir_of = '0;
		repeat (4) @(negedge sys_clk);
		rst = 1'b0;

		fd = $fopen("verification/dma_patterns.txt", "r");
		if (fd == 0)
			stop_run("Cannot open verification/dma_patterns.txt");
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				n_read = $fgets(skip, fd);
			end else begin
				if ($fscanf(fd, "%h %h %h %h", p0, p1, p2, p3) != 4)
					stop_run("Malformed line in the pattern file");
				ch = p0[0];
				case (op)
					"W": begin
						if (p0[6:4] == 3'd0 && !p0[2] && p0[1:0] == REG_CTRL)
							dir_of[p0[CHAN_BIT]] = p1[CTRL_DIR];
						reg_write(p0[6:0], p1);
					end
					"R": begin
						reg_read(p0[6:0], got);
						check_eq(got, p1, $sformatf("read of io_addr %h", p0[6:0]));
					end
					"M": begin
						for (int i = 0; i < p1; i++)
							mem[8'(p0 + i)] = 8'(p2 + i);
					end
					"G": begin
						pbyte[ch] = p1[7:0];
						jitter[ch] = p2[0];
						dack_cnt[ch] = 0;
						pause[ch] = 0;
						if (ch == 1)
							f8_seen.delete();
						else
							x8_seen.delete();
						obs.delete();
						want[ch] = 1'b1;
					end
					"E": transfer_end(ch, p1, p2, p3[7:0]);
					"I": begin
						repeat (4) @(negedge sys_clk);
						check_eq(cpu_irq, p0, "cpu_irq level");
					end
					"A": beat_order(p0, p1, p2);
					default: stop_run($sformatf("Unknown operation %s in the pattern file", op));
				endcase
			end
		end
		$fclose(fd);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/dma.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma import dma_pkg::*; #(
	parameter int COUNT_W = 16
) (
	input  logic        sys_clk,
	input  logic        rst,
	input  logic [31:0] in_dat,
	input  logic [6:0]  io_addr,
	input  logic        regs_wr,
	input  logic        regs_rd,
	output logic [31:0] rd_dat,
	output logic        cpu_irq,
	output logic        mem_req,
	output logic        mem_rw,
	output logic [31:0] mem_addr,
	output logic [7:0]  mem_wdat,
	input  logic        mem_ack,
	input  logic [7:0]  mem_rdat,
	input  logic [1:0]  dreq,
	input  logic [7:0]  x8ad_in,
	input  logic [7:0]  f8ad_in,
	output logic [1:0]  dack,
	output logic [7:0]  x8_out,
	output logic [7:0]  f8_out
);

	reg_wr_t                      reg_wr;
	mem_req_t                     x8_req, f8_req;
	logic                         x8_ack, f8_ack;
	logic                         x8_done, f8_done;
	logic [32+COUNT_W+CTRL_W-1:0] x8_regs, f8_regs;
	logic [31:0]                  status;

	dma_reg_decode #(.COUNT_W(COUNT_W)) dma_reg_decode (.sys_clk(sys_clk), .rst(rst),
		.io_addr(io_addr), .in_dat(in_dat), .regs_wr(regs_wr), .regs_rd(regs_rd),
		.x8_regs(x8_regs), .f8_regs(f8_regs), .status(status),
		.reg_wr(reg_wr), .rd_dat(rd_dat));

	dma8 #(.COUNT_W(COUNT_W), .CHAN(1'b0)) dmax8 (.sys_clk(sys_clk), .rst(rst),
		.reg_wr(reg_wr), .dreq(dreq[0]), .dma8ad_in(x8ad_in), .grant_ack(x8_ack),
		.mem_rdat(mem_rdat), .mem_req(x8_req), .dack(dack[0]), .dma8_out(x8_out),
		.done(x8_done), .regs(x8_regs));

	dma8 #(.COUNT_W(COUNT_W), .CHAN(1'b1)) dmaf8 (.sys_clk(sys_clk), .rst(rst),
		.reg_wr(reg_wr), .dreq(dreq[1]), .dma8ad_in(f8ad_in), .grant_ack(f8_ack),
		.mem_rdat(mem_rdat), .mem_req(f8_req), .dack(dack[1]), .dma8_out(f8_out),
		.done(f8_done), .regs(f8_regs));

	dma_mem_arb dma_mem_arb (.sys_clk(sys_clk), .rst(rst),
		.x8_req(x8_req), .f8_req(f8_req), .mem_ack(mem_ack),
		.mem_req(mem_req), .mem_rw(mem_rw), .mem_addr(mem_addr), .mem_wdat(mem_wdat),
		.x8_ack(x8_ack), .f8_ack(f8_ack));

	dma_status dma_status (.sys_clk(sys_clk), .rst(rst), .reg_wr(reg_wr),
		.x8_done(x8_done), .f8_done(f8_done), .status(status), .cpu_irq(cpu_irq));

endmodule

`default_nettype wire

// ==== verilog/dma_status.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_status import dma_pkg::*; (
	input  logic        sys_clk,
	input  logic        rst,
	input  reg_wr_t     reg_wr,
	input  logic        x8_done,
	input  logic        f8_done,
	output logic [31:0] status,
	output logic        cpu_irq
);

	logic [1:0] flag_q;
	logic [1:0] ie_q;
	logic [1:0] clr;

	assign clr = (reg_wr.valid && (reg_wr.sel == REG_STATUS)) ? reg_wr.data[1:0] : 2'b00;

	// ========================================================================
	// Done flags and interrupt enables
	// ========================================================================

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			flag_q  <= '0;
			ie_q    <= '0;
			cpu_irq <= 1'b0;
		end else begin
			// A new done beats a clear in the same cycle.
			flag_q  <= {f8_done, x8_done} | (flag_q & ~clr);
			cpu_irq <= |(flag_q & ie_q);
			if (reg_wr.valid && (reg_wr.sel == REG_CTRL))
				ie_q[reg_wr.chan] <= reg_wr.data[CTRL_IE];
		end
	end

	// Flags in bits 1:0, enables in bits 3:2.
	assign status = {28'd0, ie_q, flag_q};

endmodule

`default_nettype wire

// ==== verilog/dma_mem_arb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_mem_arb import dma_pkg::*; (
	input  logic        sys_clk,
	input  logic        rst,
	input  mem_req_t    x8_req,
	input  mem_req_t    f8_req,
	input  logic        mem_ack,
	output logic        mem_req,
	output logic        mem_rw,
	output logic [31:0] mem_addr,
	output logic [7:0]  mem_wdat,
	output logic        x8_ack,
	output logic        f8_ack
);

	logic     busy_q;
	logic     own_q;
	logic     last_q;
	logic     cur;
	mem_req_t sel;

	// Owner is locked for a whole beat, otherwise the channel that lost last time goes first.
	always_comb begin
		if (busy_q)
			cur = own_q;
		else if (x8_req.req && f8_req.req)
			cur = ~last_q;
		else
			cur = f8_req.req;
		sel = cur ? f8_req : x8_req;
	end

	assign mem_req  = sel.req;
	assign mem_rw   = sel.wr;
	assign mem_addr = sel.addr;
	assign mem_wdat = sel.wdat;

	assign x8_ack = mem_ack && mem_req && !cur;
	assign f8_ack = mem_ack && mem_req && cur;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			own_q  <= 1'b0;
			last_q <= 1'b1;
		end else if (mem_ack && mem_req) begin
			busy_q <= 1'b0;
			last_q <= cur;
		end else if (!busy_q && mem_req) begin
			busy_q <= 1'b1;
			own_q  <= cur;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dma8.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma8 import dma_pkg::*; #(
	parameter int   COUNT_W = 16,
	parameter logic CHAN    = 1'b0
) (
	input  logic                          sys_clk,
	input  logic                          rst,
	input  reg_wr_t                       reg_wr,
	input  logic                          dreq,
	input  logic [7:0]                    dma8ad_in,
	input  logic                          grant_ack,
	input  logic [7:0]                    mem_rdat,
	output mem_req_t                      mem_req,
	output logic                          dack,
	output logic [7:0]                    dma8_out,
	output logic                          done,
	output logic [32+COUNT_W+CTRL_W-1:0]  regs
);

	chan_state_e         state;
	logic [31:0]         addr_q;
	logic [COUNT_W-1:0]  cnt_q;
	logic [CTRL_W-1:0]   ctrl_q;
	logic [7:0]          wdat_q;
	logic                wr_hit;

	assign wr_hit = reg_wr.valid && (reg_wr.chan == CHAN);

	// ========================================================================
	// Transfer engine
	// ========================================================================

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state    <= ST_IDLE;
			addr_q   <= '0;
			cnt_q    <= '0;
			ctrl_q   <= '0;
			dack     <= 1'b0;
			dma8_out <= '0;
		end else begin
			dack <= grant_ack;
			case (state)
				ST_IDLE: begin
					if (ctrl_q[CTRL_EN] && (cnt_q != '0) && dreq)
						state <= ST_REQ;
				end
				ST_REQ, ST_ACK: begin
					if (grant_ack) begin
						addr_q <= addr_q + 32'd1;
						cnt_q  <= cnt_q - 1'b1;
						if (!ctrl_q[CTRL_DIR])
							dma8_out <= mem_rdat;
						// Last byte ends the transfer.
						if (cnt_q == COUNT_W'(1)) begin
							state           <= ST_DONE;
							ctrl_q[CTRL_EN] <= 1'b0;
						end else begin
							state <= ST_IDLE;
						end
					end else begin
						state <= ST_ACK;
					end
				end
				default: state <= ST_IDLE;
			endcase

			// Host writes win over the engine's own updates.
			if (wr_hit) begin
				case (reg_wr.sel)
					REG_ADDR:  addr_q <= reg_wr.data;
					REG_COUNT: cnt_q  <= reg_wr.data[COUNT_W-1:0];
					REG_CTRL:  ctrl_q <= reg_wr.data[CTRL_W-1:0];
					default:   ;
				endcase
			end
		end
	end

	// Peripheral byte is sampled while idle and held through the beat.
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE)
			wdat_q <= dma8ad_in;
	end

	assign mem_req = '{
		req:  (state == ST_REQ) || (state == ST_ACK),
		wr:   ctrl_q[CTRL_DIR],
		addr: addr_q,
		wdat: wdat_q
	};

	assign done = (state == ST_DONE);
	assign regs = {addr_q, cnt_q, ctrl_q};

endmodule

`default_nettype wire

// ==== verilog/dma_reg_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_reg_decode import dma_pkg::*; #(
	parameter int COUNT_W = 16
) (
	input  logic                          sys_clk,
	input  logic                          rst,
	input  logic [6:0]                    io_addr,
	input  logic [31:0]                   in_dat,
	input  logic                          regs_wr,
	input  logic                          regs_rd,
	input  logic [32+COUNT_W+CTRL_W-1:0]  x8_regs,
	input  logic [32+COUNT_W+CTRL_W-1:0]  f8_regs,
	input  logic [31:0]                   status,
	output reg_wr_t                       reg_wr,
	output logic [31:0]                   rd_dat
);

	logic                         chan_hit;
	logic                         stat_hit;
	logic [32+COUNT_W+CTRL_W-1:0] sel_regs;
	logic [31:0]                  cnt_ext;
	logic [31:0]                  ctrl_ext;
	logic [31:0]                  rd_mux;

	// Channel registers sit at offsets 0..2 of each 8-word bank.
	assign chan_hit = (io_addr[6:4] == 3'b000) && !io_addr[2] && (io_addr[1:0] != 2'b11);
	assign stat_hit = (io_addr == ADDR_STATUS);

	always_comb begin
		sel_regs = io_addr[CHAN_BIT] ? f8_regs : x8_regs;
		cnt_ext = '0;
		cnt_ext[COUNT_W-1:0] = sel_regs[CTRL_W +: COUNT_W];
		ctrl_ext = '0;
		ctrl_ext[CTRL_W-1:0] = sel_regs[CTRL_W-1:0];
		if (stat_hit) begin
			rd_mux = status;
		end else if (!chan_hit) begin
			rd_mux = '0;
		end else begin
			case (reg_sel_e'(io_addr[1:0]))
				REG_ADDR:  rd_mux = sel_regs[32+COUNT_W+CTRL_W-1 -: 32];
				REG_COUNT: rd_mux = cnt_ext;
				default:   rd_mux = ctrl_ext;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			reg_wr <= '0;
			rd_dat <= '0;
		end else begin
			reg_wr.valid <= regs_wr && (chan_hit || stat_hit);
			reg_wr.chan  <= io_addr[CHAN_BIT];
			reg_wr.sel   <= stat_hit ? REG_STATUS : reg_sel_e'(io_addr[1:0]);
			reg_wr.data  <= in_dat;
			if (regs_rd)
				rd_dat <= rd_mux;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

	// ========================================================================
	// Register map
	// ========================================================================

	typedef enum logic [1:0] {
		REG_ADDR   = 2'd0,
		REG_COUNT  = 2'd1,
		REG_CTRL   = 2'd2,
		REG_STATUS = 2'd3
	} reg_sel_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_REQ  = 2'd1,
		ST_ACK  = 2'd2,
		ST_DONE = 2'd3
	} chan_state_e;

	typedef struct packed {
		logic        valid;
		logic        chan;
		reg_sel_e    sel;
		logic [31:0] data;
	} reg_wr_t;

	// Write set means peripheral to memory.
	typedef struct packed {
		logic        req;
		logic        wr;
		logic [31:0] addr;
		logic [7:0]  wdat;
	} mem_req_t;

	localparam int CTRL_EN  = 0;
	localparam int CTRL_DIR = 1;
	localparam int CTRL_IE  = 2;
	localparam int CTRL_W   = 3;

	localparam logic [6:0] ADDR_STATUS = 7'h04;
	localparam int         CHAN_BIT    = 3;

endpackage

`default_nettype wire
